/* Makefile */
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module tb_fphub_sqrt

sim:
	verilator --binary --timing --assert -f vlog.f --top-module tb_fphub_sqrt \
		-o tb_fphub_sqrt
	./obj_dir/tb_fphub_sqrt 2>&1 | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@grep -q "No errors" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* hdl/fphub_sqrt.sv */
module fphub_sqrt (
    input  logic                clk,
    input  logic                rst_l,
    input  logic                req,
    input  sqrt_pkg::fp_word_t  x,
    output logic                ack,
    output sqrt_pkg::fp_word_t  res,
    output logic                busy
);

    logic                   load;
    logic                   step_en;
    sqrt_pkg::step_t        step;
    sqrt_pkg::residual_t    init_sig;
    sqrt_pkg::exponent_t    res_exp;
    sqrt_pkg::root_digit_e  digit;
    sqrt_pkg::root_pair_t   f_terms;
    sqrt_pkg::root_t        root;

    sqrt_control sqrt_control_i (
        .clk     (clk),
        .rst_l   (rst_l),
        .req     (req),
        .ack     (ack),
        .busy    (busy),
        .load    (load),
        .step_en (step_en),
        .step    (step)
    );

    sqrt_operand_unpack sqrt_operand_unpack_i (
        .clk      (clk),
        .rst_l    (rst_l),
        .load     (load),
        .x        (x),
        .init_sig (init_sig),
        .res_exp  (res_exp)
    );

    sqrt_residual sqrt_residual_i (
        .clk      (clk),
        .rst_l    (rst_l),
        .load     (load),
        .step_en  (step_en),
        .init_sig (init_sig),
        .f_terms  (f_terms),
        .digit    (digit)
    );

    sqrt_root_convert sqrt_root_convert_i (
        .clk     (clk),
        .rst_l   (rst_l),
        .load    (load),
        .step_en (step_en),
        .digit   (digit),
        .step    (step),
        .f_terms (f_terms),
        .root    (root)
    );

    // Leading one of the root sits at bit 24 and the LSB is the guard digit
    assign res = ack ? {1'b0, res_exp, root[sqrt_pkg::ROOT_W-3:1]} : '0;

endmodule

/* hdl/sqrt_control.sv */
module sqrt_control (
    input  logic             clk,
    input  logic             rst_l,
    input  logic             req,
    output logic             ack,
    output logic             busy,
    output logic             load,
    output logic             step_en,
    output sqrt_pkg::step_t  step
);

    sqrt_pkg::sqrt_state_e state;

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            state <= sqrt_pkg::IDLE;
            step  <= '0;
            ack   <= 1'b0;
        end else begin
            case (state)
                sqrt_pkg::IDLE: begin
                    if (req) begin
                        state <= sqrt_pkg::LOAD;
                    end
                end
                sqrt_pkg::LOAD: begin
                    state <= sqrt_pkg::ITERATE;
                    step  <= '0;
                end
                sqrt_pkg::ITERATE: begin
                    if (step == sqrt_pkg::step_t'(sqrt_pkg::N_ITER - 1)) begin
                        state <= sqrt_pkg::DONE;       // Last digit taken
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                sqrt_pkg::DONE: begin
                    if (!ack) begin
                        ack <= 1'b1;                   // Result settled
                    end else if (!req) begin
                        ack   <= 1'b0;                 // Four-phase close
                        state <= sqrt_pkg::IDLE;
                    end
                end
                default: begin
                    state <= sqrt_pkg::IDLE;
                end
            endcase
        end
    end

    assign busy    = (state != sqrt_pkg::IDLE);
    assign load    = (state == sqrt_pkg::LOAD);
    assign step_en = (state == sqrt_pkg::ITERATE);

    // ack comes a fixed latency after the operand load
    a_ack_after_load: assert property (@(posedge clk) disable iff (!rst_l)
        $rose(ack) |-> $past(load, sqrt_pkg::N_ITER + 2));

    a_step_range: assert property (@(posedge clk) disable iff (!rst_l)
        step_en |-> step < sqrt_pkg::step_t'(sqrt_pkg::N_ITER));

endmodule

/* hdl/sqrt_operand_unpack.sv */
module sqrt_operand_unpack (
    input  logic                 clk,
    input  logic                 rst_l,
    input  logic                 load,
    input  sqrt_pkg::fp_word_t   x,
    output sqrt_pkg::residual_t  init_sig,
    output sqrt_pkg::exponent_t  res_exp
);

    sqrt_pkg::exponent_t          x_exp;
    sqrt_pkg::mantissa_t          x_mant;
    logic                         x_sign;
    logic signed [sqrt_pkg::EXP_W:0] exp_unb;   // Unbiased with a spare sign bit
    logic signed [sqrt_pkg::EXP_W:0] exp_half;
    logic [sqrt_pkg::MANT_W+1:0]  hub_sig;      // 1.m plus ILSB

    assign x_sign = x[sqrt_pkg::EXP_W+sqrt_pkg::MANT_W];
    assign x_exp  = x[sqrt_pkg::MANT_W +: sqrt_pkg::EXP_W];
    assign x_mant = x[sqrt_pkg::MANT_W-1:0];

    assign exp_unb  = $signed({1'b0, x_exp})
                    - $signed((sqrt_pkg::EXP_W+1)'(sqrt_pkg::EXP_BIAS));
    assign exp_half = exp_unb >>> 1;             // Floors negative values too

    assign hub_sig = {1'b1, x_mant, 1'b1};

    // Odd exponent doubles the significand so that the halved exponent is exact
    // Bit 24 weighs 1/4 here so x lands in [1/4, 1)
    // Residual captures this straight from the held operand on load
    always_comb begin
        if (exp_unb[0]) begin
            init_sig = sqrt_pkg::residual_t'({hub_sig, 1'b0});
        end else begin
            init_sig = sqrt_pkg::residual_t'(hub_sig);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            res_exp  <= sqrt_pkg::exponent_t'(exp_half
                      + $signed((sqrt_pkg::EXP_W+1)'(sqrt_pkg::EXP_BIAS)));
        end
    end

    // Only positive normal operands are handled
    a_operand_normal: assert property (@(posedge clk) disable iff (!rst_l)
        load |-> (!x_sign && x_exp != '0 && x_exp != '1));

endmodule

/* hdl/sqrt_pkg.sv */
package sqrt_pkg;

    // Single-precision HUB widths
    localparam int EXP_W    = 8;
    localparam int MANT_W   = 23;
    localparam int EXP_BIAS = 127;

    // Residual holds a sign, two integer bits and 26 fraction bits
    localparam int RES_W  = 29;
    // Root holds one integer bit and 25 fraction bits
    localparam int ROOT_W = 26;
    localparam int EST_W  = 4;             // Sign, two int bits, one frac bit
    localparam int N_ITER = 25;            // One digit per step
    localparam int STEP_W = 5;

    typedef logic [EXP_W-1:0]          exponent_t;
    typedef logic [MANT_W-1:0]         mantissa_t;
    typedef logic [RES_W-1:0]          residual_t;
    typedef logic [ROOT_W-1:0]         root_t;
    typedef logic [STEP_W-1:0]         step_t;
    typedef logic [EXP_W+MANT_W:0]     fp_word_t;

    // Recurrence starts from Q0 = 1 and w0 = x - 1
    localparam residual_t RES_MINUS_ONE = {3'b111, {(RES_W-3){1'b0}}};
    localparam root_t     ROOT_ONE      = {1'b1, {(ROOT_W-1){1'b0}}};

    typedef struct packed {
        residual_t sum;
        residual_t carry;
    } residual_cs_t;

    // Root and root minus one ulp or the two terms built from them
    typedef struct packed {
        root_t q;
        root_t qm;
    } root_pair_t;

    typedef enum logic [1:0] {
        DIGIT_ZERO = 2'b00,
        DIGIT_POS  = 2'b01,
        DIGIT_NEG  = 2'b11
    } root_digit_e;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        ITERATE,
        DONE
    } sqrt_state_e;

endpackage

/* hdl/sqrt_residual.sv */
module sqrt_residual (
    input  logic                   clk,
    input  logic                   rst_l,
    input  logic                   load,
    input  logic                   step_en,
    input  sqrt_pkg::residual_t    init_sig,
    input  sqrt_pkg::root_pair_t   f_terms,
    output sqrt_pkg::root_digit_e  digit
);

    localparam int PAD_W = sqrt_pkg::RES_W - sqrt_pkg::ROOT_W - 1;

    sqrt_pkg::residual_cs_t        w;
    sqrt_pkg::residual_t           sum2;
    sqrt_pkg::residual_t           carry2;
    sqrt_pkg::residual_t           w_full;
    sqrt_pkg::residual_t           term;
    sqrt_pkg::residual_t           sum_nx;
    sqrt_pkg::residual_t           maj;
    logic [sqrt_pkg::EST_W-1:0]    est;
    logic                          cin;

    assign sum2   = w.sum << 1;
    assign carry2 = w.carry << 1;

    // Estimate of 2w truncated below weight 1/2
    assign est = sum2[sqrt_pkg::RES_W-1 -: sqrt_pkg::EST_W]
               + carry2[sqrt_pkg::RES_W-1 -: sqrt_pkg::EST_W];

    // Full residual whose sign alone matters
    assign w_full = w.sum + w.carry;

    // During a step the digit comes from the estimate
    // Between steps it reports the final residual sign for the root correction
    always_comb begin
        if (!step_en) begin
            digit = w_full[sqrt_pkg::RES_W-1] ? sqrt_pkg::DIGIT_NEG : sqrt_pkg::DIGIT_ZERO;
        end else if (est == '1) begin
            digit = sqrt_pkg::DIGIT_ZERO;        // y = -1/2
        end else if (!est[sqrt_pkg::EST_W-1]) begin
            digit = sqrt_pkg::DIGIT_POS;         // y >= 0
        end else begin
            digit = sqrt_pkg::DIGIT_NEG;         // y <= -1
        end
    end

    // q = +1 subtracts 2Q + d as inverse plus carry-in
    // q = -1 adds 2QM + 3d
    always_comb begin
        case (digit)
            sqrt_pkg::DIGIT_POS: term = ~{{PAD_W{1'b0}}, f_terms.q, 1'b0};
            sqrt_pkg::DIGIT_NEG: term = {{PAD_W{1'b0}}, f_terms.qm, 1'b0};
            default:             term = '0;
        endcase
    end

    assign cin    = (digit == sqrt_pkg::DIGIT_POS);   // +1 of the two's complement
    assign sum_nx = sum2 ^ carry2 ^ term;
    assign maj    = (sum2 & carry2) | (sum2 & term) | (carry2 & term);

    always_ff @(posedge clk) begin
        if (load) begin
            w.sum   <= init_sig;
            w.carry <= sqrt_pkg::RES_MINUS_ONE;  // w0 = x - 1
        end else if (step_en) begin
            if (digit == sqrt_pkg::DIGIT_ZERO) begin
                w.sum   <= sum2;                 // Plain shift
                w.carry <= carry2;
            end else begin
                w.sum   <= sum_nx;
                w.carry <= {maj[sqrt_pkg::RES_W-2:0], cin};  // Free LSB takes carry-in
            end
        end
    end

    // Estimate and digit must resolve on every step or the root gets garbage
    a_digit_known: assert property (@(posedge clk) disable iff (!rst_l)
        step_en |-> !$isunknown({est, digit}));

endmodule

/* hdl/sqrt_root_convert.sv */
module sqrt_root_convert (
    input  logic                   clk,
    input  logic                   rst_l,
    input  logic                   load,
    input  logic                   step_en,
    input  sqrt_pkg::root_digit_e  digit,
    input  sqrt_pkg::step_t        step,
    output sqrt_pkg::root_pair_t   f_terms,
    output sqrt_pkg::root_t        root
);

    sqrt_pkg::root_pair_t  r;          // Q and Q minus one ulp of the current step
    sqrt_pkg::root_t       d_bit;      // Weight 2^-(step+1)
    sqrt_pkg::root_t       twice_q;
    sqrt_pkg::root_t       twice_qm;

    // Same index serves the root register and the term field
    assign d_bit = sqrt_pkg::root_t'(1) << (sqrt_pkg::ROOT_W - 2 - int'(step));

    // Term field bit i carries residual bit i+1 so 2Q is a one-bit shift
    // Top bit of Q drops out as it is zero whenever the term is selected
    assign twice_q  = {r.q[sqrt_pkg::ROOT_W-2:0], 1'b0};
    assign twice_qm = {r.qm[sqrt_pkg::ROOT_W-2:0], 1'b0};

    // Low bits of 2Q are still clear so OR does the add
    assign f_terms.q  = twice_q | d_bit;                       // 2Q + d
    assign f_terms.qm = twice_qm | d_bit | (d_bit << 1);       // 2QM + 3d

    // Negative final residual means the root overshoots by one ulp
    assign root = (digit == sqrt_pkg::DIGIT_NEG) ? r.qm : r.q;

    always_ff @(posedge clk) begin
        if (load) begin
            r.q  <= sqrt_pkg::ROOT_ONE;   // Integer digit 1
            r.qm <= '0;
        end else if (step_en) begin
            case (digit)
                sqrt_pkg::DIGIT_POS: begin
                    r.q  <= r.q | d_bit;
                    r.qm <= r.q;
                end
                sqrt_pkg::DIGIT_NEG: begin
                    r.q  <= r.qm | d_bit;   // Borrow taken from QM
                    r.qm <= r.qm;
                end
                default: begin
                    r.qm <= r.qm | d_bit;   // Q unchanged
                end
            endcase
        end
    end

    // QM always trails Q by exactly one ulp of the step just done
    a_pair_gap: assert property (@(posedge clk) disable iff (!rst_l)
        step_en |=> (r.q - r.qm) == $past(d_bit));

endmodule

/* verif/fphub_sqrt_vectors.svh */
`ifndef FPHUB_SQRT_VECTORS_SVH
`define FPHUB_SQRT_VECTORS_SVH

// Directed cases
// Columns are the operand word, then the expected result word
task automatic load_directed_vectors();
    // Powers of four give exact roots
    add_vector(32'h4080_0000, 32'h4000_0000);   // 4.0 -> 2.0
    add_vector(32'h3F80_0000, 32'h3F80_0000);   // 1.0 -> 1.0
    add_vector(32'h4180_0000, 32'h4080_0000);   // 16.0 -> 4.0
    add_vector(32'h3E80_0000, 32'h3F00_0000);   // 0.25 -> 0.5
    add_vector(32'h3D80_0000, 32'h3E80_0000);   // 0.0625 -> 0.25

    // Odd exponents double the significand first
    add_vector(32'h4000_0000, 32'h3FB5_04F3);   // 2.0
    add_vector(32'h3F00_0000, 32'h3F35_04F3);   // 0.5 with the exponent flooring to -1
    add_vector(32'h4110_0000, 32'h4040_0000);   // 9.0 -> 3.0
    add_vector(32'h4040_0000, 32'h3FDD_B3D7);   // 3.0

    // Even exponents with a mantissa
    add_vector(32'h3FC0_0000, 32'h3F9C_C470);   // 1.5 truncated rather than rounded
    add_vector(32'h42C8_0000, 32'h4120_0000);   // 100.0 -> 10.0
    add_vector(32'h3F80_0001, 32'h3F80_0000);   // One ulp above 1.0

    // Largest mantissa
    add_vector(32'h3FFF_FFFF, 32'h3FB5_04F3);   // Even exponent
    add_vector(32'h407F_FFFF, 32'h3FFF_FFFF);   // Odd exponent with a root just under 2
    add_vector(32'h3F7F_FFFF, 32'h3F7F_FFFF);   // Just under 1.0

    // Exponent range ends
    add_vector(32'h0080_0000, 32'h2000_0000);   // Smallest normal
    add_vector(32'h7F00_0000, 32'h5F35_04F3);
    add_vector(32'h7F7F_FFFF, 32'h5F7F_FFFF);   // Largest normal
endtask

`endif

/* verif/tb_fphub_sqrt.sv */
module tb_fphub_sqrt;

    localparam int LATENCY     = sqrt_pkg::N_ITER + 2;   // LOAD, iterate steps, DONE
    localparam int TIMEOUT     = 100;
    localparam int N_RANDOM    = 40;
    localparam int HOLD_CYCLES = 3;                      // Cycles req stays up after ack

    typedef struct packed {
        sqrt_pkg::fp_word_t x;
        sqrt_pkg::fp_word_t expected;
    } sqrt_vector_t;

    logic               clk;
    logic               rst_l;
    logic               req;
    sqrt_pkg::fp_word_t x;
    logic               ack;
    sqrt_pkg::fp_word_t res;
    logic               busy;

    sqrt_vector_t       vectors[$];     // Directed cases followed by random ones
    integer             seed;

    fphub_sqrt fphub_sqrt_i (
        .clk   (clk),
        .rst_l (rst_l),
        .req   (req),
        .x     (x),
        .ack   (ack),
        .res   (res),
        .busy  (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // Period 8
    end

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] t=%0t %s expected 0x%08h actual 0x%08h",
                 $time, name, expected, actual);
        stop_on_error();
    endtask

    task automatic report_problem(input string msg);
        $display("%s at t=%0t", msg, $time);
        stop_on_error();
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else report_mismatch(name, expected, actual);
    endtask

    // Inputs change and outputs are sampled just after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic add_vector(input sqrt_pkg::fp_word_t op,
                              input sqrt_pkg::fp_word_t expected);
        sqrt_vector_t v;
        v.x        = op;
        v.expected = expected;
        vectors.push_back(v);
    endtask

    `include "fphub_sqrt_vectors.svh"

    // Bitwise integer square root from the top bit down
    function automatic logic [23:0] int_sqrt(input logic [47:0] v);
        logic [23:0] r;
        logic [23:0] trial;
        r = '0;
        for (int b = 23; b >= 0; b--) begin
            trial = r | (24'd1 << b);
            if ({24'd0, trial} * {24'd0, trial} <= v) begin
                r = trial;                      // Bit fits under the operand
            end
        end
        return r;
    endfunction

    // Result word of the HUB root with the mantissa truncated
    function automatic sqrt_pkg::fp_word_t expected_root(input sqrt_pkg::fp_word_t op);
        int          ee;
        logic [47:0] h;
        logic [23:0] q;
        logic [7:0]  e_res;
        ee = int'(op[30:23]) - 127;
        h  = (48'd1 << 24) + (48'(op[22:0]) << 1) + 48'd1;   // 1.m plus ILSB
        if (ee[0]) begin
            h = h << 23;                        // Odd exponent
        end else begin
            h = h << 22;
        end
        q     = int_sqrt(h);
        e_res = 8'((ee >>> 1) + 127);           // Floor of half
        return {1'b0, e_res, q[22:0]};
    endfunction

    task automatic add_random_vectors();
        sqrt_pkg::fp_word_t op;
        for (int i = 0; i < N_RANDOM; i++) begin
            op[31]    = 1'b0;
            op[30:23] = 8'(1 + ({$random(seed)} % 254));   // Normal exponents only
            op[22:0]  = 23'($random(seed));
            add_vector(op, expected_root(op));
        end
    endtask

    // One full four-phase transfer
    task automatic run_request(input sqrt_vector_t v);
        int cycles;
        x   = v.x;
        req = 1'b1;
        next_cycle();                           // Edge that samples req
        check_value("busy", 32'd1, 32'(busy));
        cycles = 1;
        while (ack !== 1'b1) begin
            if (cycles >= TIMEOUT) begin
                report_problem("Timed out waiting for ack to rise");
            end
            next_cycle();
            cycles++;
        end
        check_value("ack latency", 32'(LATENCY), 32'(cycles - 1));
        check_value("res", v.expected, res);
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            next_cycle();
            check_value("ack", 32'd1, 32'(ack));
            check_value("res", v.expected, res);    // Held while req stays up
        end
        req    = 1'b0;
        cycles = 0;
        while (ack !== 1'b0) begin
            if (cycles >= TIMEOUT) begin
                report_problem("Timed out waiting for ack to fall");
            end
            next_cycle();
            cycles++;
        end
        check_value("busy", 32'd0, 32'(busy));  // Back in IDLE
        check_value("res", 32'd0, res);
    endtask

    initial begin
        seed  = 42909;
        rst_l = 1'b0;
        req   = 1'b0;
        x     = '0;
        repeat (5) begin
            next_cycle();
        end
        check_value("ack", 32'd0, 32'(ack));
        check_value("busy", 32'd0, 32'(busy));
        check_value("res", 32'd0, res);
        rst_l = 1'b1;
        next_cycle();
        check_value("ack", 32'd0, 32'(ack));
        check_value("busy", 32'd0, 32'(busy));
        check_value("res", 32'd0, res);

        load_directed_vectors();
        add_random_vectors();
        foreach (vectors[i]) begin
            run_request(vectors[i]);            // Next req right after ack falls
        end

        $display("No errors");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verif
hdl/sqrt_pkg.sv
hdl/sqrt_operand_unpack.sv
hdl/sqrt_residual.sv
hdl/sqrt_root_convert.sv
hdl/sqrt_control.sv
hdl/fphub_sqrt.sv
verif/tb_fphub_sqrt.sv
